/* source/imuldiv_pkg.sv */
// imuldiv package
// widths, function codes, iteration count and state encodings shared by
// every stage of the iterative multiply/divide unit

package imuldiv_pkg;

  // ----------------------------------------
  // data widths
  // ----------------------------------------

  // one operand, or one half of a result
  typedef logic [31:0] word_t;

  // full product, or remainder in the upper word and quotient in the lower
  typedef logic [63:0] wide_t;

  // ----------------------------------------
  // function codes
  // ----------------------------------------

  typedef logic [1:0] fn_t;

  // signed multiply, 64-bit product
  localparam fn_t FN_MUL  = 2'd0;
  // unsigned multiply, 64-bit product
  localparam fn_t FN_MULU = 2'd1;
  // signed divide, remainder follows the dividend sign
  localparam fn_t FN_DIV  = 2'd2;
  // unsigned divide
  localparam fn_t FN_DIVU = 2'd3;

  // ----------------------------------------
  // iteration control
  // ----------------------------------------

  // counts 0 .. ITERS-1, wraps back to zero after the last step
  typedef logic [4:0] iter_t;

  // one bit of multiplier or quotient per iteration
  localparam int ITERS = 32;

  // ----------------------------------------
  // state machines
  // ----------------------------------------

  // decode: wait for request, pulse start, wait for response to leave
  typedef enum logic [1:0] {DEC_IDLE, DEC_ISSUE, DEC_WAIT} dec_state_t;

  // both execute units
  typedef enum logic {EXE_IDLE, EXE_RUN} exe_state_t;

  // result: fix is the first cycle of a fresh response, hold is a stall
  typedef enum logic [1:0] {RES_IDLE, RES_FIX, RES_HOLD} res_state_t;

endpackage

/* source/imuldiv_decode.sv */
// imuldiv decode stage
// accepts one request at a time, turns signed operands into magnitudes,
// records the sign and divide-by-zero flags and starts one execute unit

`timescale 1ns/1ns

module imuldiv_decode (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  imuldiv_pkg::fn_t   req_fn,
  input  imuldiv_pkg::word_t req_a,
  input  imuldiv_pkg::word_t req_b,
  input  logic               resp_fire,
  output logic               mul_start,
  output logic               div_start,
  output imuldiv_pkg::word_t mag_a,
  output imuldiv_pkg::word_t mag_b,
  output imuldiv_pkg::word_t raw_a,
  output logic               neg_res,
  output logic               neg_rem,
  output logic               div_zero,
  output logic               is_div
);
  import imuldiv_pkg::*;

  dec_state_t state;
  logic       accept;
  logic       signed_fn;
  logic       a_neg;
  logic       b_neg;
  word_t      a_abs;
  word_t      b_abs;

  // only idle takes a request, so req_a/req_b may change freely afterwards
  assign req_rdy = (state == DEC_IDLE);
  assign accept  = req_val && req_rdy;

  // ----------------------------------------
  // operand conditioning
  // ----------------------------------------

  assign signed_fn = (req_fn == FN_MUL) || (req_fn == FN_DIV);

  // unsigned functions never see a sign bit
  assign a_neg = signed_fn && req_a[31];
  assign b_neg = signed_fn && req_b[31];

  // two's complement magnitude
  // most negative value maps onto itself, which is the right unsigned magnitude
  assign a_abs = a_neg ? (~req_a) + word_t'(1) : req_a;
  assign b_abs = b_neg ? (~req_b) + word_t'(1) : req_b;

  // ----------------------------------------
  // control
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DEC_IDLE;
    end else begin
      case (state)
        DEC_IDLE: begin
          if (accept) begin
            state <= DEC_ISSUE;
          end
        end
        // single cycle, the start pulse goes out here
        DEC_ISSUE: state <= DEC_WAIT;
        DEC_WAIT: begin
          // back to idle once the response has left the unit
          if (resp_fire) begin
            state <= DEC_IDLE;
          end
        end
        default: state <= DEC_IDLE;
      endcase
    end
  end

  // operands and flags held steady until the next accepted request
  always_ff @(posedge clk) begin
    if (accept) begin
      mag_a    <= a_abs;
      mag_b    <= b_abs;
      raw_a    <= req_a;
      // product and quotient sign
      neg_res  <= a_neg ^ b_neg;
      // remainder takes the dividend sign
      neg_rem  <= a_neg;
      div_zero <= (req_b == '0);
      is_div   <= (req_fn == FN_DIV) || (req_fn == FN_DIVU);
    end
  end

  // exactly one of the two fires, for one cycle
  assign mul_start = (state == DEC_ISSUE) && !is_div;
  assign div_start = (state == DEC_ISSUE) && is_div;

endmodule

/* source/imuldiv_mul_iter.sv */
// imuldiv shift-and-add multiplier
// multiplies two 32-bit magnitudes into a 64-bit product, one multiplier
// bit per cycle over 32 cycles, with a done pulse after the last step

`timescale 1ns/1ns

module imuldiv_mul_iter (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  imuldiv_pkg::word_t a,
  input  imuldiv_pkg::word_t b,
  output logic               done,
  output imuldiv_pkg::wide_t prod
);
  import imuldiv_pkg::*;

  exe_state_t state;
  iter_t      count;
  logic       last;

  // multiplicand moves left across the full product width
  wide_t mcand;
  // multiplier moves right, bit 0 picks the add
  word_t mplier;
  // running partial product
  wide_t acc;
  wide_t acc_next;

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // conditional add for the current multiplier bit
  assign acc_next = mplier[0] ? acc + mcand : acc;

  always_ff @(posedge clk) begin
    if (start) begin
      // load, no arithmetic on this edge
      mcand  <= {32'b0, a};
      mplier <= b;
      acc    <= '0;
    end else if (state == EXE_RUN) begin
      acc    <= acc_next;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // acc stops moving when the unit goes idle, so the product stays put
  assign prod = acc;

  // ----------------------------------------
  // control
  // ----------------------------------------

  // step ITERS-1 is the final add
  assign last = (count == iter_t'(ITERS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= EXE_IDLE;
      count <= '0;
      done  <= 1'b0;
    end else begin
      // done is a single-cycle pulse
      done <= 1'b0;
      case (state)
        EXE_IDLE: begin
          if (start) begin
            state <= EXE_RUN;
            count <= '0;
          end
        end
        EXE_RUN: begin
          // counter wraps to zero on the last step
          count <= count + iter_t'(1);
          if (last) begin
            state <= EXE_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= EXE_IDLE;
      endcase
    end
  end

endmodule

/* source/imuldiv_div_iter.sv */
// imuldiv restoring divider
// divides two 32-bit magnitudes, producing one quotient bit per cycle over
// 32 cycles, then pulses done with quotient and remainder

`timescale 1ns/1ns

module imuldiv_div_iter (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  imuldiv_pkg::word_t a,
  input  imuldiv_pkg::word_t b,
  output logic               done,
  output imuldiv_pkg::word_t quot,
  output imuldiv_pkg::word_t rem
);
  import imuldiv_pkg::*;

  exe_state_t state;
  iter_t      count;
  logic       last;

  // partial remainder, always below the divisor between steps
  word_t rem_r;
  // dividend bits leave at the top while quotient bits enter at the bottom
  word_t quo_r;
  word_t divisor;

  // partial remainder shifted left with the next dividend bit
  logic [32:0] shifted;
  // trial subtraction, extra top bit is the borrow
  logic [33:0] diff;
  logic        fits;

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  assign shifted = {rem_r, quo_r[31]};
  assign diff    = {1'b0, shifted} - {2'b00, divisor};

  // no borrow means the divisor fits, so keep the difference
  // zero divisor always fits, giving all ones and the dividend as remainder
  assign fits = ~diff[33];

  always_ff @(posedge clk) begin
    if (start) begin
      rem_r   <= '0;
      quo_r   <= a;
      divisor <= b;
    end else if (state == EXE_RUN) begin
      // either result is below the divisor, so 32 bits are enough
      rem_r <= fits ? diff[31:0] : shifted[31:0];
      quo_r <= {quo_r[30:0], fits};
    end
  end

  // stable once the unit is idle again
  assign quot = quo_r;
  assign rem  = rem_r;

  // ----------------------------------------
  // control
  // ----------------------------------------

  assign last = (count == iter_t'(ITERS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= EXE_IDLE;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        EXE_IDLE: begin
          if (start) begin
            state <= EXE_RUN;
            count <= '0;
          end
        end
        EXE_RUN: begin
          count <= count + iter_t'(1);
          // last quotient bit lands on this edge
          if (last) begin
            state <= EXE_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= EXE_IDLE;
      endcase
    end
  end

endmodule

/* source/imuldiv_result.sv */
// imuldiv result stage
// applies sign correction and the divide-by-zero rule, registers the packed
// result and holds it on the response port until the consumer takes it

`timescale 1ns/1ns

module imuldiv_result (
  input  logic               clk,
  input  logic               reset,
  input  logic               mul_done,
  input  logic               div_done,
  input  imuldiv_pkg::wide_t mul_prod,
  input  imuldiv_pkg::word_t div_quot,
  input  imuldiv_pkg::word_t div_rem,
  input  logic               is_div,
  input  logic               neg_res,
  input  logic               neg_rem,
  input  logic               div_zero,
  input  imuldiv_pkg::word_t dividend,
  output logic               resp_val,
  input  logic               resp_rdy,
  output imuldiv_pkg::wide_t resp_result,
  output logic               resp_fire
);
  import imuldiv_pkg::*;

  res_state_t state;
  logic       any_done;
  wide_t      mul_fix;
  word_t      quot_fix;
  word_t      rem_fix;
  wide_t      div_fix;

  // ----------------------------------------
  // sign correction
  // ----------------------------------------

  assign mul_fix  = neg_res ? (~mul_prod) + wide_t'(1) : mul_prod;
  assign quot_fix = neg_res ? (~div_quot) + word_t'(1) : div_quot;
  assign rem_fix  = neg_rem ? (~div_rem) + word_t'(1) : div_rem;

  // divide by zero ignores the magnitudes and the signs
  // most negative over minus one needs nothing here, it wraps on its own
  assign div_fix = div_zero ? {dividend, {32{1'b1}}} : {rem_fix, quot_fix};

  assign any_done = mul_done || div_done;

  // response register, only written by a done pulse
  always_ff @(posedge clk) begin
    if (any_done) begin
      resp_result <= is_div ? div_fix : mul_fix;
    end
  end

  // ----------------------------------------
  // response handshake
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RES_IDLE;
    end else begin
      case (state)
        RES_IDLE: begin
          if (any_done) begin
            state <= RES_FIX;
          end
        end
        // fresh result on the port, stall into hold if not taken
        RES_FIX:  state <= resp_rdy ? RES_IDLE : RES_HOLD;
        RES_HOLD: begin
          if (resp_rdy) begin
            state <= RES_IDLE;
          end
        end
        default: state <= RES_IDLE;
      endcase
    end
  end

  assign resp_val  = (state != RES_IDLE);
  // tells decode the unit may take the next request
  assign resp_fire = resp_val && resp_rdy;

endmodule

/* source/imuldiv_unit.sv */
// imuldiv unit top level
// one val/rdy request port and one val/rdy response port around decode,
// the two iterative execute units and the result stage

`timescale 1ns/1ns

module imuldiv_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  imuldiv_pkg::fn_t   req_fn,
  input  imuldiv_pkg::word_t req_a,
  input  imuldiv_pkg::word_t req_b,
  output logic               resp_val,
  input  logic               resp_rdy,
  output imuldiv_pkg::wide_t resp_result
);
  import imuldiv_pkg::*;

  // decode to execute
  logic  mul_start;
  logic  div_start;
  word_t mag_a;
  word_t mag_b;

  // decode to result, stable for the whole operation
  logic  neg_res;
  logic  neg_rem;
  logic  div_zero;
  logic  is_div;
  word_t raw_a;

  // execute to result
  logic  mul_done;
  logic  div_done;
  wide_t mul_prod;
  word_t div_quot;
  word_t div_rem;

  // result back to decode
  logic  resp_fire;

  imuldiv_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .req_fn    (req_fn),
    .req_a     (req_a),
    .req_b     (req_b),
    .resp_fire (resp_fire),
    .mul_start (mul_start),
    .div_start (div_start),
    .mag_a     (mag_a),
    .mag_b     (mag_b),
    .raw_a     (raw_a),
    .neg_res   (neg_res),
    .neg_rem   (neg_rem),
    .div_zero  (div_zero),
    .is_div    (is_div)
  );

  imuldiv_mul_iter u_mul (
    .clk   (clk),
    .reset (reset),
    .start (mul_start),
    .a     (mag_a),
    .b     (mag_b),
    .done  (mul_done),
    .prod  (mul_prod)
  );

  imuldiv_div_iter u_div (
    .clk   (clk),
    .reset (reset),
    .start (div_start),
    .a     (mag_a),
    .b     (mag_b),
    .done  (div_done),
    .quot  (div_quot),
    .rem   (div_rem)
  );

  imuldiv_result u_result (
    .clk         (clk),
    .reset       (reset),
    .mul_done    (mul_done),
    .div_done    (div_done),
    .mul_prod    (mul_prod),
    .div_quot    (div_quot),
    .div_rem     (div_rem),
    .is_div      (is_div),
    .neg_res     (neg_res),
    .neg_rem     (neg_rem),
    .div_zero    (div_zero),
    .dividend    (raw_a),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .resp_fire   (resp_fire)
  );

endmodule

/* verif/imuldiv_tb.sv */
// imuldiv unit testbench
// drives multiplies and divides through the val/rdy ports, checks results
// against a behavioural model and checks latency and handshake rules

`timescale 1ns/1ns

module imuldiv_tb;
  import imuldiv_pkg::*;

  localparam int MAX_OPS        = 400;
  localparam int CYCLES_PER_OP  = 40;
  localparam int TIMEOUT_CYCLES = MAX_OPS * CYCLES_PER_OP;
  localparam int LATENCY        = 34;
  localparam int N_RANDOM       = 100;
  localparam int N_STALL        = 60;

  logic  clk = 1'b0;
  logic  reset;
  logic  req_val;
  logic  req_rdy;
  fn_t   req_fn;
  word_t req_a;
  word_t req_b;
  logic  resp_val;
  logic  resp_rdy;
  wide_t resp_result;

  // scoreboard
  wide_t       exp_q[$];
  string       name_q[$];
  wide_t       exp_now;
  string       name_now;
  int          n_sent = 0;
  int          n_resp = 0;
  int          cycle_cnt = 0;
  // cycles since the last accepted request
  int          lat_cnt = 0;
  wide_t       held_result;
  logic        stall_mode = 1'b0;

  word_t corner_vals[5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                            32'h8000_0000, 32'h7fff_ffff};

  imuldiv_unit dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #2 clk = ~clk;

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // behavioural reference for all four functions
  function automatic wide_t model_result(input fn_t fn, input word_t a, input word_t b);
    logic signed [63:0] sa64;
    logic signed [63:0] sb64;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] q;
    logic signed [31:0] r;
    wide_t              res;
    sa64 = {{32{a[31]}}, a};
    sb64 = {{32{b[31]}}, b};
    sa = a;
    sb = b;
    case (fn)
      FN_MUL:  res = sa64 * sb64;
      FN_MULU: res = {32'b0, a} * {32'b0, b};
      FN_DIVU: begin
        if (b == 32'h0) res = {a, 32'hffff_ffff};
        else res = {a % b, a / b};
      end
      default: begin
        if (b == 32'h0) begin
          res = {a, 32'hffff_ffff};
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          // overflow wraps to the most negative value
          res = {32'h0, 32'h8000_0000};
        end else begin
          // native operators truncate toward zero, remainder follows dividend
          q = sa / sb;
          r = sa % sb;
          res = {r, q};
        end
      end
    endcase
    return res;
  endfunction

  function automatic string corner_name(input fn_t fn, input word_t a, input word_t b);
    if (fn == FN_MUL || fn == FN_MULU) return "mul_corner";
    if (b == 32'h0) return "div_by_zero";
    if (fn == FN_DIV && a == 32'h8000_0000 && b == 32'hffff_ffff) return "div_overflow";
    return "div_corner";
  endfunction

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic send_op(input fn_t fn, input word_t a, input word_t b, input string nm);
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    while (!req_rdy) begin
      @(posedge clk);
      #1;
    end
    exp_q.push_back(model_result(fn, a, b));
    name_q.push_back(nm);
    n_sent++;
    @(posedge clk);
    #1;
    // scramble the operands so the DUT must rely on its captured copies
    req_val = 1'b0;
    req_a   = $urandom();
    req_b   = $urandom();
    req_fn  = fn_t'($urandom_range(0, 3));
  endtask

  // ----------------------------------------
  // response side
  // ----------------------------------------

  // random low spans on resp_rdy while stalling, otherwise always ready
  always @(posedge clk) begin
    #1;
    resp_rdy = stall_mode ? ($urandom_range(0, 3) == 0) : 1'b1;
  end

  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        abort_run("a response arrived with no request outstanding");
      end else begin
        exp_now  = exp_q.pop_front();
        name_now = name_q.pop_front();
        assert (resp_result == exp_now) n_resp++;
        else abort_run($sformatf("[FAIL] %s: expected %h, actual %h",
                                 name_now, exp_now, resp_result));
      end
    end
  end

  always @(posedge clk) begin
    if (reset || (req_val && req_rdy)) lat_cnt <= 0;
    else lat_cnt <= lat_cnt + 1;
    held_result <= resp_result;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("timeout, the DUT stopped returning responses");
    end
  end

  // ----------------------------------------
  // protocol checks
  // ----------------------------------------

  a_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> (lat_cnt == LATENCY))
    else abort_run($sformatf("[FAIL] latency: expected %0d, actual %0d",
                             LATENCY, $sampled(lat_cnt)));

  a_busy_after_accept: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |=> !req_rdy)
    else abort_run("req_rdy stayed high after a request was accepted");

  // nothing new gets in while a response is on the port
  a_busy_with_resp: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !req_rdy)
    else abort_run("req_rdy was high while a response was pending");

  a_ready_only_after_fire: assert property (@(posedge clk) disable iff (reset)
    $rose(req_rdy) |-> $past(resp_val && resp_rdy))
    else abort_run("req_rdy rose without a response transfer");

  a_ready_after_fire: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |=> req_rdy)
    else abort_run("req_rdy did not return one cycle after the response transfer");

  a_hold_val: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val)
    else abort_run("resp_val dropped before the response was taken");

  a_hold_data: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_result == held_result))
    else abort_run($sformatf("[FAIL] stall_hold: expected %h, actual %h",
                             $sampled(held_result), $sampled(resp_result)));

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    void'($urandom(56));
    reset     = 1'b1;
    req_val   = 1'b0;
    req_fn    = FN_MUL;
    req_a     = '0;
    req_b     = '0;
    resp_rdy  = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    assert (req_rdy === 1'b1 && resp_val === 1'b0)
    else abort_run("after reset req_rdy is not high or resp_val is not low");

    // multiply corners, both signed and unsigned
    foreach (corner_vals[i]) begin
      foreach (corner_vals[j]) begin
        send_op(FN_MUL, corner_vals[i], corner_vals[j], "mul_corner");
        send_op(FN_MULU, corner_vals[i], corner_vals[j], "mul_corner");
      end
    end

    repeat (N_RANDOM) begin
      send_op($urandom_range(0, 1) ? FN_MUL : FN_MULU, $urandom(), $urandom(), "mul_random");
    end

    // divide corners cover divide by zero and the signed overflow
    foreach (corner_vals[i]) begin
      foreach (corner_vals[j]) begin
        send_op(FN_DIV, corner_vals[i], corner_vals[j],
                corner_name(FN_DIV, corner_vals[i], corner_vals[j]));
        send_op(FN_DIVU, corner_vals[i], corner_vals[j],
                corner_name(FN_DIVU, corner_vals[i], corner_vals[j]));
      end
    end

    // shifted divisors give quotients of every size, signs mix freely
    repeat (N_RANDOM) begin
      send_op($urandom_range(0, 1) ? FN_DIV : FN_DIVU, $urandom(),
              $urandom() >> $urandom_range(0, 31), "div_random");
    end

    // back-pressure with all four functions
    stall_mode = 1'b1;
    repeat (N_STALL) begin
      send_op(fn_t'($urandom_range(0, 3)), $urandom(),
              $urandom() >> $urandom_range(0, 31), "backpressure");
    end

    // drain, the timeout guards this loop
    while (exp_q.size() != 0) @(posedge clk);
    stall_mode = 1'b0;
    repeat (4) @(posedge clk);

    if (n_resp == n_sent && n_sent > 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      abort_run($sformatf("response count mismatch, %0d sent and %0d checked",
                          n_sent, n_resp));
    end
  end

endmodule

/* imuldiv.f */
source/imuldiv_pkg.sv
source/imuldiv_decode.sv
source/imuldiv_mul_iter.sv
source/imuldiv_div_iter.sv
source/imuldiv_result.sv
source/imuldiv_unit.sv
verif/imuldiv_tb.sv
